/* dram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "zmem_defines.svh"

module dram_ctrl
(
	input  wire                      fclk,
	input  wire                      rst_n,
	input  wire zmem_pkg::dram_req_t dram_req,
	output zmem_pkg::dram_rsp_t      dram_rsp
);
	import zmem_pkg::*;

	localparam int unsigned RFSH_W = (`REFRESH_EVERY > 1) ? $clog2(`REFRESH_EVERY) : 1;
	localparam int unsigned DEPTH  = 1 << `DRAM_DEPTH_LOG2;

	dram_phase_t                 ph;
	logic [RFSH_W-1:0]           rot;      // rotation count
	logic                        rfsh_rot; // slot stolen by refresh
	logic                        accept;
	logic                        rd_pend;  // read waiting for c2
	logic                        strobe_r;
	dram_word_t                  rd_word;
	logic [`DRAM_DEPTH_LOG2-1:0] idx;      // upper address bits dropped
	dram_word_t                  mem [0:DEPTH-1];

	assign rfsh_rot = (rot == RFSH_W'(`REFRESH_EVERY - 1));
	assign accept   = dram_req.req && !rfsh_rot && (ph == PH_C3);
	assign idx      = dram_req.addr[`DRAM_DEPTH_LOG2-1:0];

	// c0 c1 c2 c3 and round again
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ph  <= PH_C0;
			rot <= '0;
		end
		else
		begin
			ph <= dram_phase_t'(ph + 2'd1);
			if (ph == PH_C3)
			begin
				if (rfsh_rot)
					rot <= '0;
				else
					rot <= rot + 1'b1;
			end
		end
	end

	// read answer in c2 of the next rotation
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_pend  <= 1'b0;
			strobe_r <= 1'b0;
		end
		else
		begin
			strobe_r <= rd_pend && (ph == PH_C1);
			if (accept && dram_req.rnw)
				rd_pend <= 1'b1;
			else if (ph == PH_C1)
				rd_pend <= 1'b0;
		end
	end

	// word array with byte writes
	always_ff @(posedge fclk)
	begin
		if (accept)
		begin
			if (dram_req.rnw)
				rd_word <= mem[idx];
			else if (dram_req.wrbsel)
				mem[idx][`ZD_W-1:0] <= dram_req.wrdata;    // odd byte
			else
				mem[idx][`DW_W-1:`ZD_W] <= dram_req.wrdata; // even byte
		end
	end

	always_comb
	begin
		dram_rsp.next   = !rfsh_rot; // low for the whole refresh rotation
		dram_rsp.strobe = strobe_r;
		dram_rsp.rddata = rd_word;
	end

	// every strobe answers a read taken three cycles earlier
	a_strobe_after_read: assert property (@(posedge fclk) disable iff (!rst_n)
		dram_rsp.strobe |-> $past(accept && dram_req.rnw, 3));

endmodule

`default_nettype wire

/* mem_pager.sv */
`timescale 1ns/1ps
`default_nettype none
`include "zmem_defines.svh"

module mem_pager
(
	input  wire                     fclk,
	input  wire                     rst_n,
	input  wire zmem_pkg::zaddr_t   zaddr,   // only the low byte is decoded
	input  wire zmem_pkg::zdata_t   zd_in,
	input  wire zmem_pkg::zbus_t    zbus,
	input  wire                     zpos,
	output zmem_pkg::win_map_t      win_map
);

	logic io_wr;   // i/o write on the bus
	logic io_wr_r; // as seen at the last zpos
	logic io_beg;  // first zpos of the write

	// inta also has iorq low so m1 must be high
	assign io_wr  = !zbus.iorq_n && !zbus.wr_n && zbus.m1_n;
	assign io_beg = zpos && io_wr && !io_wr_r;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			io_wr_r <= 1'b0;
		else if (zpos)
			io_wr_r <= io_wr;
	end

	// window registers come up as ram page 0
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			win_map <= '0;
		else if (io_beg)
		begin
			case (zaddr[7:0])
				`PAGE_PORT:        win_map.win0.page <= zd_in;
				`PAGE_PORT + 8'd1: win_map.win1.page <= zd_in;
				`PAGE_PORT + 8'd2: win_map.win2.page <= zd_in;
				`PAGE_PORT + 8'd3: win_map.win3.page <= zd_in;
				`PAGE_PORT + 8'd4:
				begin
					// one flag bit per window
					win_map.win0.romnram <= zd_in[0];
					win_map.win1.romnram <= zd_in[1];
					win_map.win2.romnram <= zd_in[2];
					win_map.win3.romnram <= zd_in[3];
				end
				default: ; // other ports are not ours
			endcase
		end
	end

endmodule

`default_nettype wire

/* tb_zmem_sys.sv */
`timescale 1ns/1ps
`default_nettype none
`include "zmem_defines.svh"

module tb_zmem_sys;
	import zmem_pkg::*;

	localparam int WAIT_MAX = 200; // fclk cycles a zclk level may last

	logic     fclk;
	logic     rst_n;
	zaddr_t   za;
	zdata_t   zd_in;
	zbus_t    zbus;
	turbo_t   turbo;
	logic     romrw_en;
	logic     zclk;
	zdata_t   zd_out;
	logic     zd_ena;
	rompg_t   rompg;
	logic     romoe_n;
	logic     romwe_n;
	logic     csrom;

	integer   seed = 32'h80a8;
	int       errors;
	int       checks;
	int       tests;
	int       err_mark;      // errors before the running test
	page_t    win_page [4];  // expected window map
	logic     win_rom [4];
	zdata_t   ref_mem [int]; // expected ram, byte addressed
	zaddr_t   addrs [$];     // even addresses written so far

	zmem_sys u_zmem_sys (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.za       (za),
		.zd_in    (zd_in),
		.zbus     (zbus),
		.turbo    (turbo),
		.romrw_en (romrw_en),
		.zclk     (zclk),
		.zd_out   (zd_out),
		.zd_ena   (zd_ena),
		.rompg    (rompg),
		.romoe_n  (romoe_n),
		.romwe_n  (romwe_n),
		.csrom    (csrom)
	);

	always #2 fclk = ~fclk; // 4 ns period

	// byte index into dram, upper word bits fold away
	function automatic int ref_index(input page_t pg, input zaddr_t a);
		logic [21:0] full;
		full = {pg, a[13:0]};
		return int'(full & ((22'd1 << (`DRAM_DEPTH_LOG2 + 1)) - 22'd1));
	endfunction

	function automatic zdata_t ref_read(input zaddr_t a);
		int idx;
		idx = ref_index(win_page[a[15:14]], a);
		if (ref_mem.exists(idx))
			return ref_mem[idx];
		else
			return 'x; // never written
	endfunction

	// zclk half period in fclk cycles
	function automatic int half_len(input turbo_t t);
		case (t)
			TURBO_14: return 1;
			TURBO_7:  return 2;
			default:  return 4; // 3.5 mhz
		endcase
	endfunction

	task automatic check_zdata(input string name, input zdata_t got, input zdata_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_rompg(input string name, input rompg_t got, input rompg_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_len(input string name, input int got, input int exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	// zclk seen on falling fclk, stall counted in fclk cycles
	task automatic wait_zclk(input logic level);
		int n;
		n = 0;
		while (zclk !== level && n < WAIT_MAX)
		begin
			@(negedge fclk);
			n++;
		end
		if (n >= WAIT_MAX)
		begin
			$display("zclk did not change level within %0d fclk cycles", WAIT_MAX);
			$display("Simulation finished: FAIL");
			$finish;
		end
	endtask

	// both levels of an idle zclk, counted in fclk cycles
	task automatic measure_zclk(input turbo_t t);
		int hi;
		int lo;
		wait_zclk(1'b1);
		wait_zclk(1'b0);
		wait_zclk(1'b1);             // first cycle of a fresh high level
		hi = 0;
		while (zclk === 1'b1 && hi < WAIT_MAX)
		begin
			@(negedge fclk);
			hi++;
		end
		lo = 0;
		while (zclk === 1'b0 && lo < WAIT_MAX)
		begin
			@(negedge fclk);
			lo++;
		end
		check_len("zclk high", hi, half_len(t));
		check_len("zclk low", lo, half_len(t));
	endtask

	task automatic io_write(input logic [7:0] port, input zdata_t d);
		wait_zclk(1'b1);             // T1
		za    = {8'h00, port};
		zd_in = d;
		wait_zclk(1'b0);
		wait_zclk(1'b1);             // T2, iorq and wr together
		zbus.iorq_n = 1'b0;
		zbus.wr_n   = 1'b0;
		wait_zclk(1'b0);
		wait_zclk(1'b1);             // TW
		wait_zclk(1'b0);
		wait_zclk(1'b1);             // T3
		wait_zclk(1'b0);
		zbus.iorq_n = 1'b1;
		zbus.wr_n   = 1'b1;
		if (port >= `PAGE_PORT && port < `PAGE_PORT + 8'd4)
			win_page[port - `PAGE_PORT] = d;
		else if (port == `PAGE_PORT + 8'd4)
		begin
			for (int w = 0; w < 4; w++)
				win_rom[w] = d[w];
		end
	endtask

	task automatic mem_write(input zaddr_t a, input zdata_t d, output logic we_n);
		wait_zclk(1'b1);             // T1
		za    = a;
		zd_in = d;
		wait_zclk(1'b0);
		zbus.mreq_n = 1'b0;
		wait_zclk(1'b1);             // T2
		wait_zclk(1'b0);
		zbus.wr_n = 1'b0;
		wait_zclk(1'b1);             // T3, stretched while dram is busy
		wait_zclk(1'b0);
		wait_zclk(1'b1);
		we_n = romwe_n;              // still inside the cycle
		zbus.mreq_n = 1'b1;
		zbus.wr_n   = 1'b1;
		wait_zclk(1'b0);
		if (!win_rom[a[15:14]])
			ref_mem[ref_index(win_page[a[15:14]], a)] = d;
	endtask

	task automatic mem_read(input zaddr_t a, output zdata_t d, output logic oe_n,
		output logic cs, output logic ena, output rompg_t pg);
		wait_zclk(1'b1);             // T1
		za = a;
		wait_zclk(1'b0);
		zbus.mreq_n = 1'b0;
		zbus.rd_n   = 1'b0;
		wait_zclk(1'b1);             // T2
		wait_zclk(1'b0);
		wait_zclk(1'b1);             // T3
		wait_zclk(1'b0);
		wait_zclk(1'b1);
		oe_n = romoe_n;              // strobes still low here
		cs   = csrom;
		ena  = zd_ena;
		pg   = rompg;
		zbus.mreq_n = 1'b1;
		zbus.rd_n   = 1'b1;
		wait_zclk(1'b0);
		d = zd_out;                  // read buffer holds until the next fetch
	endtask

	// read one byte and compare against the model
	task automatic read_check(input zaddr_t a);
		zdata_t d;
		logic   oe_n;
		logic   cs;
		logic   ena;
		rompg_t pg;
		mem_read(a, d, oe_n, cs, ena, pg);
		check_zdata("zd_out", d, ref_read(a));
		check_flag("zd_ena", ena, 1'b1);
	endtask

	task automatic write_byte(input zaddr_t a, input zdata_t d);
		logic we_n;
		mem_write(a, d, we_n);
		check_flag("romwe_n", we_n, 1'b1);
	endtask

	// random word pairs in windows 1..3
	task automatic rand_rw(input int n);
		zaddr_t a;
		int     w;
		for (int i = 0; i < n; i++)
		begin
			w = 1 + ($unsigned($random(seed)) % 3);
			a[15:14] = w[1:0];
			a[13:0]  = $random(seed);
			a[0]     = 1'b0;
			write_byte(a, $random(seed));          // even byte
			write_byte(a | 16'h1, $random(seed));  // odd byte
			addrs.push_back(a);
		end
		foreach (addrs[i])
		begin
			read_check(addrs[i]);
			read_check(addrs[i] | 16'h1);
		end
	endtask

	// odd byte right after its even byte, then a write to the same word
	task automatic cache_rw(input zaddr_t base);
		write_byte(base, $random(seed));
		write_byte(base | 16'h1, $random(seed));
		read_check(base);
		read_check(base | 16'h1);      // hit at 14 mhz
		write_byte(base | 16'h1, $random(seed));
		read_check(base | 16'h1);      // stale word must be gone
		read_check(base);
	endtask

	task automatic long_run(input int n);
		zaddr_t a;
		for (int i = 0; i < n; i++)
		begin
			a = addrs[$unsigned($random(seed)) % addrs.size()];
			read_check(a | zaddr_t'($random(seed) & 1));
		end
	endtask

	task automatic start_test();
		err_mark = errors;
		tests++;
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "errors");
	endtask

	initial
	begin
		zdata_t d;
		logic   oe_n;
		logic   cs;
		logic   ena;
		logic   we_n;
		rompg_t pg;

		fclk     = 1'b0;
		rst_n    = 1'b0;
		za       = '0;
		zd_in    = '0;
		zbus     = '1;           // all strobes idle
		turbo    = TURBO_14;
		romrw_en = 1'b0;
		errors   = 0;
		checks   = 0;
		tests    = 0;
		for (int w = 0; w < 4; w++)
		begin
			win_page[w] = '0;
			win_rom[w]  = 1'b0;
		end
		repeat (3) @(posedge fclk);
		@(negedge fclk);
		rst_n = 1'b1;

		start_test();
		check_flag("zd_ena", zd_ena, 1'b0);
		check_flag("romoe_n", romoe_n, 1'b1);
		check_flag("romwe_n", romwe_n, 1'b1);
		check_flag("csrom", csrom, 1'b0);
		end_test("reset state");

		start_test();
		io_write(`PAGE_PORT, 8'h25);
		io_write(`PAGE_PORT + 8'd1, 8'h01);
		io_write(`PAGE_PORT + 8'd2, 8'h02);
		io_write(`PAGE_PORT + 8'd3, 8'h03);
		io_write(`PAGE_PORT + 8'd4, 8'h01);   // window 0 is rom
		mem_read(16'h0123, d, oe_n, cs, ena, pg);
		check_flag("csrom", cs, 1'b1);
		check_rompg("rompg", pg, 5'h05);
		check_flag("romoe_n", oe_n, 1'b0);
		check_flag("zd_ena", ena, 1'b0);
		mem_write(16'h0200, 8'h5a, we_n);
		check_flag("romwe_n", we_n, 1'b1);    // rom locked
		romrw_en = 1'b1;
		mem_write(16'h0200, 8'h5a, we_n);
		check_flag("romwe_n", we_n, 1'b0);
		romrw_en = 1'b0;
		write_byte(16'h4000, 8'h3c);
		mem_read(16'h4000, d, oe_n, cs, ena, pg);
		check_flag("csrom", cs, 1'b0);
		check_flag("romoe_n", oe_n, 1'b1);
		check_flag("zd_ena", ena, 1'b1);
		check_zdata("zd_out", d, ref_read(16'h4000));
		end_test("window map and rom strobes");

		start_test();
		io_write(`PAGE_PORT + 8'd3, 8'h47);   // another ram page
		measure_zclk(TURBO_14);
		rand_rw(12);
		end_test("random ram at 14 mhz");

		start_test();
		cache_rw(16'h8a40);
		end_test("read cache at 14 mhz");

		start_test();
		turbo = TURBO_7;
		measure_zclk(TURBO_7);
		rand_rw(4);
		cache_rw(16'h5512);
		end_test("ram at 7 mhz");

		start_test();
		turbo = TURBO_35;
		measure_zclk(TURBO_35);
		rand_rw(4);
		cache_rw(16'hc3fe);
		end_test("ram at 3.5 mhz");

		start_test();
		turbo = TURBO_14;
		long_run(150);
		turbo = TURBO_7;
		long_run(40);
		end_test("long read runs over refresh");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* zclk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module zclk_gen
(
	input  wire                   fclk,
	input  wire                   rst_n,
	input  wire zmem_pkg::turbo_t turbo,     // cpu speed select
	input  wire                   cpu_stall, // stretch request from zmem
	output logic                  zclk,
	output logic                  zpos,      // cycle before zclk rises
	output logic                  zneg       // cycle before zclk falls
);
	import zmem_pkg::*;

	logic [1:0] half;     // half period minus one
	logic [1:0] cnt;      // cycles left before the next strobe
	logic       edge_now; // zclk toggles at the end of this cycle
	logic       level_hi; // zclk level over the coming half

	// half period is 1, 2 or 4 fclk
	always_comb
	begin
		case (turbo)
			TURBO_14: half = 2'd0;
			TURBO_7:  half = 2'd1;
			default:  half = 2'd3; // 3.5 mhz
		endcase
	end

	assign edge_now = zpos | zneg;
	assign level_hi = edge_now ? zpos : zclk;

	// strobes are registered one cycle ahead of the edge they announce
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			zclk <= 1'b0;
			cnt  <= 2'd0;
			zpos <= 1'b0;
			zneg <= 1'b0;
		end
		else
		begin
			zpos <= 1'b0;
			zneg <= 1'b0;
			if (zpos)
				zclk <= 1'b1;
			else if (zneg)
				zclk <= 1'b0;

			if (edge_now && half != 2'd0)
				cnt <= half - 2'd1;     // new half period starts
			else if (!edge_now && cnt != 2'd0)
				cnt <= cnt - 2'd1;
			else if (level_hi)
				zneg <= !cpu_stall;     // held at 0 so zclk stays high
			else
				zpos <= 1'b1;
		end
	end

	// edge strobes never collide
	a_strobes_apart: assert property (@(posedge fclk) disable iff (!rst_n)
		!(zpos && zneg));

endmodule

`default_nettype wire

/* zmem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "zmem_defines.svh"

module zmem
(
	input  wire                      fclk,
	input  wire                      rst_n,
	input  wire zmem_pkg::zaddr_t    za,
	input  wire zmem_pkg::zdata_t    zd_in,
	input  wire zmem_pkg::zbus_t     zbus,
	input  wire                      zpos,
	input  wire                      zneg,
	input  wire zmem_pkg::turbo_t    turbo,
	input  wire zmem_pkg::win_map_t  win_map,
	input  wire                      romrw_en,  // rom writable
	input  wire zmem_pkg::dram_rsp_t dram_rsp,
	output zmem_pkg::zdata_t         zd_out,
	output logic                     zd_ena,    // we own the read data
	output zmem_pkg::rompg_t         rompg,
	output logic                     romoe_n,
	output logic                     romwe_n,
	output logic                     csrom,
	output zmem_pkg::dram_req_t      dram_req,
	output logic                     cpu_stall  // holds zclk high
);
	import zmem_pkg::*;

	win_cfg_t    cfg;          // addressed window
	dram_phase_t ph;           // slot phase mirror
	logic        c3;
	logic        accept;       // request taken this cycle
	logic        turbo14;
	logic        opfetch;
	logic        memrd;
	logic        memwr;
	logic        ramreq;
	logic        ramrd;
	logic        ramwr;
	logic        ramrd_reg;    // read already sent
	logic        ramwr_reg;
	logic        cpureq_357;
	logic        r_mreq_n;     // mreq at the previous zneg
	logic        dram_beg;     // start of a 14 mhz dram cycle
	logic        cache_hit;
	logic        stall14_ini;
	logic        stall14_cyc;
	logic        stall14_cycrd;
	logic        stall14_fin;
	logic        pending_req;
	logic        rnw_r;
	logic        io_r;
	dram_word_t  rd_buf;
	logic [`ZA_W-1:1] cached_addr;
	logic        cached_valid;

	// window select
	always_comb
	begin
		case (za[15:14])
			2'd0:    cfg = win_map.win0;
			2'd1:    cfg = win_map.win1;
			2'd2:    cfg = win_map.win2;
			default: cfg = win_map.win3;
		endcase
	end

	assign rompg   = cfg.page[`ROMPG_W-1:0];
	assign csrom   = cfg.romnram;
	assign romoe_n = zbus.rd_n | zbus.mreq_n | !cfg.romnram;
	assign romwe_n = zbus.wr_n | zbus.mreq_n | !cfg.romnram | !romrw_en;
	assign zd_ena  = !zbus.mreq_n && !zbus.rd_n && !cfg.romnram;

	// same reset and step as dram_ctrl so the two phases match
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			ph <= PH_C0;
		else
			ph <= dram_phase_t'(ph + 2'd1);
	end

	assign c3      = (ph == PH_C3);
	assign accept  = c3 && dram_rsp.next;
	assign turbo14 = (turbo == TURBO_14);

	assign opfetch = !zbus.mreq_n && !zbus.m1_n;
	assign memrd   = !zbus.mreq_n && !zbus.rd_n;
	assign memwr   = !zbus.mreq_n && zbus.rd_n && zbus.rfsh_n; // rd_n high means write

	// 3.5/7 mhz requests on rd/wr rising
	assign ramreq     = !zbus.mreq_n && !cfg.romnram && zbus.rfsh_n;
	assign ramrd      = ramreq && !zbus.rd_n;
	assign ramwr      = ramreq && !zbus.wr_n;
	assign cpureq_357 = (ramrd && !ramrd_reg) || (ramwr && !ramwr_reg);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ramrd_reg <= 1'b0;
			ramwr_reg <= 1'b0;
		end
		else
		begin
			if (!ramrd)
				ramrd_reg <= 1'b0;
			else if (accept)
				ramrd_reg <= 1'b1;
			if (!ramwr)
				ramwr_reg <= 1'b0;
			else if (accept)
				ramwr_reg <= 1'b1;
		end
	end

	assign cache_hit = cached_valid && (za[`ZA_W-1:1] == cached_addr);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			r_mreq_n <= 1'b1;
		else if (zneg)
			r_mreq_n <= zbus.mreq_n | !zbus.rfsh_n; // refresh counts as idle
	end

	assign dram_beg = turbo14 && zneg && r_mreq_n && !zbus.mreq_n && zbus.rfsh_n &&
		!cfg.romnram && (!cache_hit || memwr);

	// 14 mhz wait states
	// reads wait for the c3 slot then for the data strobe
	// writes wait only while no slot is free
	assign stall14_ini = dram_beg && (!dram_rsp.next || opfetch || memrd);
	assign stall14_cyc = memwr ? (pending_req && !dram_rsp.next) : stall14_cycrd;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			stall14_cycrd <= 1'b0;
			stall14_fin   <= 1'b0;
			pending_req   <= 1'b0;
		end
		else
		begin
			if (accept)
				stall14_cycrd <= 1'b0;
			else if (dram_beg && (opfetch || memrd))
				stall14_cycrd <= 1'b1;

			if (stall14_fin && dram_rsp.strobe)
				stall14_fin <= 1'b0; // data lands in rd_buf now
			else if (accept && dram_req.req && turbo14 && (opfetch || memrd))
				stall14_fin <= 1'b1;

			if (accept)
				pending_req <= 1'b0;
			else if (dram_beg)
				pending_req <= 1'b1;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (dram_beg)
			rnw_r <= !memwr;
	end

	assign cpu_stall = turbo14 ? (stall14_ini | stall14_cyc | stall14_fin) :
		(cpureq_357 && !dram_rsp.next);

	always_comb
	begin
		dram_req.req    = turbo14 ? (pending_req | dram_beg) : cpureq_357;
		dram_req.rnw    = turbo14 ? (dram_beg ? !memwr : rnw_r) : ramrd;
		dram_req.addr   = {cfg.page, za[13:1]};
		dram_req.wrdata = zd_in;
		dram_req.wrbsel = za[0];
	end

	// read word and its address
	always_ff @(posedge fclk)
	begin
		if (dram_rsp.strobe)
		begin
			rd_buf      <= dram_rsp.rddata;
			cached_addr <= za[`ZA_W-1:1];
		end
	end

	assign zd_out = za[0] ? rd_buf[`ZD_W-1:0] : rd_buf[`DW_W-1:`ZD_W]; // even byte is high

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			io_r <= 1'b0;
		else if (zpos)
			io_r <= !zbus.iorq_n;
	end

	// drop the cached word on rom access, memory write or i/o start
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			cached_valid <= 1'b0;
		else if ((zneg && r_mreq_n && !zbus.mreq_n && zbus.rfsh_n && cfg.romnram) ||
			(zneg && r_mreq_n && memwr) ||
			(zpos && !zbus.iorq_n && !io_r))
			cached_valid <= 1'b0;
		else if (dram_rsp.strobe)
			cached_valid <= 1'b1;
	end

	// dram_ctrl must see a request held until its slot takes it
	a_req_held: assert property (@(posedge fclk) disable iff (!rst_n)
		dram_req.req && !accept |=> dram_req.req);

	// cpu clock never falls on a ram read whose word is still in flight
	a_read_landed: assert property (@(posedge fclk) disable iff (!rst_n)
		zd_ena && zneg |-> !stall14_fin);

endmodule

`default_nettype wire

/* zmem_defines.svh */
`ifndef ZMEM_DEFINES_SVH
`define ZMEM_DEFINES_SVH

// z80 side
`define ZA_W            16
`define ZD_W            8

// window paging
`define PAGE_W          8
`define ROMPG_W         5      // rom pages reachable through rompg

// dram side
`define DA_W            21     // word address
`define DW_W            16     // word width
`define DRAM_DEPTH_LOG2 13     // implemented part of the word space

// i/o ports F0..F3 load window pages and F4 loads the rom flags
`define PAGE_PORT       8'hF0

// one refresh rotation out of this many
`define REFRESH_EVERY   8

`endif

/* zmem_pkg.sv */
`default_nettype none
`include "zmem_defines.svh"

package zmem_pkg;

	typedef logic [`ZA_W-1:0]    zaddr_t;     // cpu address
	typedef logic [`ZD_W-1:0]    zdata_t;     // cpu data byte
	typedef logic [`PAGE_W-1:0]  page_t;      // 16k page in a window
	typedef logic [`ROMPG_W-1:0] rompg_t;
	typedef logic [`DA_W-1:0]    dram_addr_t; // word address
	typedef logic [`DW_W-1:0]    dram_word_t;

	// cpu speed
	typedef enum logic [1:0] {
		TURBO_35 = 2'd0,
		TURBO_7  = 2'd1,
		TURBO_14 = 2'd2
	} turbo_t;

	// dram slot phases
	typedef enum logic [1:0] {
		PH_C0,
		PH_C1,
		PH_C2,
		PH_C3
	} dram_phase_t;

	// z80 control lines, all active low
	typedef struct packed {
		logic m1_n;
		logic rfsh_n;
		logic mreq_n;
		logic iorq_n;
		logic rd_n;
		logic wr_n;
	} zbus_t;

	typedef struct packed {
		logic  romnram; // 1 for rom
		page_t page;
	} win_cfg_t;

	typedef struct packed {
		win_cfg_t win3;
		win_cfg_t win2;
		win_cfg_t win1;
		win_cfg_t win0;
	} win_map_t;

	// cpu port of the dram controller
	typedef struct packed {
		logic       req;    // level until accepted
		logic       rnw;
		dram_addr_t addr;
		zdata_t     wrdata;
		logic       wrbsel; // 1 selects the low byte
	} dram_req_t;

	typedef struct packed {
		logic       next;   // slot free this rotation
		logic       strobe; // read data valid
		dram_word_t rddata;
	} dram_rsp_t;

endpackage

`default_nettype wire

/* zmem_sys.f */
+incdir+.
zmem_pkg.sv
zclk_gen.sv
mem_pager.sv
zmem.sv
dram_ctrl.sv
zmem_sys.sv
tb_zmem_sys.sv

/* zmem_sys.sv */
`timescale 1ns/1ps
`default_nettype none

module zmem_sys
(
	input  wire                    fclk,
	input  wire                    rst_n,
	input  wire zmem_pkg::zaddr_t  za,
	input  wire zmem_pkg::zdata_t  zd_in,
	input  wire zmem_pkg::zbus_t   zbus,
	input  wire zmem_pkg::turbo_t  turbo,
	input  wire                    romrw_en,
	output logic                   zclk,
	output zmem_pkg::zdata_t       zd_out,
	output logic                   zd_ena,
	output zmem_pkg::rompg_t       rompg,
	output logic                   romoe_n,
	output logic                   romwe_n,
	output logic                   csrom
);
	import zmem_pkg::*;

	logic      zpos;      // zclk edge strobes
	logic      zneg;
	logic      cpu_stall;
	win_map_t  win_map;   // pager to memory manager
	dram_req_t dram_req;
	dram_rsp_t dram_rsp;

	zclk_gen u_zclk_gen (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.turbo     (turbo),
		.cpu_stall (cpu_stall),
		.zclk      (zclk),
		.zpos      (zpos),
		.zneg      (zneg)
	);

	mem_pager u_mem_pager (
		.fclk    (fclk),
		.rst_n   (rst_n),
		.zaddr   (za),
		.zd_in   (zd_in),
		.zbus    (zbus),
		.zpos    (zpos),
		.win_map (win_map)
	);

	zmem u_zmem (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.za        (za),
		.zd_in     (zd_in),
		.zbus      (zbus),
		.zpos      (zpos),
		.zneg      (zneg),
		.turbo     (turbo),
		.win_map   (win_map),
		.romrw_en  (romrw_en),
		.dram_rsp  (dram_rsp),
		.zd_out    (zd_out),
		.zd_ena    (zd_ena),
		.rompg     (rompg),
		.romoe_n   (romoe_n),
		.romwe_n   (romwe_n),
		.csrom     (csrom),
		.dram_req  (dram_req),
		.cpu_stall (cpu_stall)
	);

	dram_ctrl u_dram_ctrl (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.dram_req (dram_req),
		.dram_rsp (dram_rsp)
	);

endmodule

`default_nettype wire
